// ==== hw/battle_defines.svh ====
`ifndef BATTLE_DEFINES_SVH
`define BATTLE_DEFINES_SVH

//////////////////////////////
// lane geometry
//////////////////////////////

// unit slots per side
`define BATTLE_SLOTS 4

// enemy spawn point, also where the enemy tower stands
`define BATTLE_FIELD_END 40

// attack reach in lane steps
`define BATTLE_RANGE 4

//////////////////////////////
// towers
//////////////////////////////

`define BATTLE_TOWER_HEALTH 100

`endif

// ==== hw/BattlePkg.sv ====
package BattlePkg;

	//////////////////////////////
	// widths with a meaning
	//////////////////////////////

	typedef logic [8:0] lanePosT;
	typedef logic [7:0] healthT;
	typedef logic [11:0] damageT;
	typedef logic [1:0] slotIdxT;
	typedef logic [2:0] slotCountT;

	typedef enum logic [1:0] {
		Basic,
		Tank,
		Brute,
		Runner
	} unitKindT;

	// one tick walks Idle -> Strike -> Apply
	typedef enum logic [1:0] {
		Idle,
		Strike,
		Apply
	} engineStateT;

	// per kind stats, indexed by unitKindT, same for both sides
	localparam healthT kindAttack [4] = '{8'd4, 8'd2, 8'd10, 8'd3};
	localparam healthT kindHealth [4] = '{8'd20, 8'd60, 8'd16, 8'd12};

endpackage

// ==== hw/LaneIf.sv ====
`timescale 1ns/1ps
`include "battle_defines.svh"

// contents of every slot on both sides of the lane
interface LaneIf;

	logic [`BATTLE_SLOTS-1:0] unitAlive;
	BattlePkg::lanePosT unitPos [`BATTLE_SLOTS];
	BattlePkg::unitKindT unitKind [`BATTLE_SLOTS];
	BattlePkg::healthT unitHealth [`BATTLE_SLOTS];

	logic [`BATTLE_SLOTS-1:0] enemyAlive;
	BattlePkg::lanePosT enemyPos [`BATTLE_SLOTS];
	BattlePkg::unitKindT enemyKind [`BATTLE_SLOTS];
	BattlePkg::healthT enemyHealth [`BATTLE_SLOTS];

	modport state (output unitAlive, unitPos, unitKind, unitHealth,
		output enemyAlive, enemyPos, enemyKind, enemyHealth);
	modport view (input unitAlive, unitPos, unitKind, unitHealth,
		input enemyAlive, enemyPos, enemyKind, enemyHealth);

endinterface

// combat result of one tick, grouped by the side that deals it
// target is a slot on the opposing side
interface StrikeIf;

	logic [`BATTLE_SLOTS-1:0] unitMask, enemyMask;
	BattlePkg::damageT unitDamage, enemyDamage;
	BattlePkg::slotIdxT unitTarget, enemyTarget;
	logic unitTowerHit, enemyTowerHit;

	modport source (output unitMask, unitDamage, unitTarget, unitTowerHit,
		output enemyMask, enemyDamage, enemyTarget, enemyTowerHit);
	modport sink (input unitMask, unitDamage, unitTarget, unitTowerHit,
		input enemyMask, enemyDamage, enemyTarget, enemyTowerHit);

endinterface

// ==== hw/BattleFront.sv ====
`timescale 1ns/1ps
`include "battle_defines.svh"

module BattleFront (
	LaneIf.view Lane,
	output BattlePkg::lanePosT FriendlyFront,
	output BattlePkg::lanePosT EnemyFront,
	output BattlePkg::slotIdxT UnitTarget,
	output BattlePkg::slotIdxT EnemyTarget,
	output BattlePkg::slotCountT UnitCount,
	output BattlePkg::slotCountT EnemyCount
);

	//////////////////////////////
	// friendly side
	//////////////////////////////

	always_comb
	begin
		// empty side reads as our own tower at 0
		FriendlyFront = '0;
		UnitCount = '0;
		UnitTarget = '0;
		for (int i = 0; i < `BATTLE_SLOTS; i++)
		begin
			if (Lane.unitAlive[i])
			begin
				UnitCount = UnitCount + BattlePkg::slotCountT'(1);
				if (Lane.unitPos[i] > FriendlyFront)
					FriendlyFront = Lane.unitPos[i];
			end
		end
		// walk down so the lowest index at the front wins
		for (int i = `BATTLE_SLOTS - 1; i >= 0; i--)
		begin
			if (Lane.unitAlive[i] && Lane.unitPos[i] == FriendlyFront)
				UnitTarget = BattlePkg::slotIdxT'(i);
		end
	end

	//////////////////////////////
	// enemy side
	//////////////////////////////

	always_comb
	begin
		// empty side reads as the enemy tower
		EnemyFront = BattlePkg::lanePosT'(`BATTLE_FIELD_END);
		EnemyCount = '0;
		EnemyTarget = '0;
		for (int i = 0; i < `BATTLE_SLOTS; i++)
		begin
			if (Lane.enemyAlive[i])
			begin
				EnemyCount = EnemyCount + BattlePkg::slotCountT'(1);
				if (Lane.enemyPos[i] < EnemyFront)
					EnemyFront = Lane.enemyPos[i];
			end
		end
		for (int i = `BATTLE_SLOTS - 1; i >= 0; i--)
		begin
			if (Lane.enemyAlive[i] && Lane.enemyPos[i] == EnemyFront)
				EnemyTarget = BattlePkg::slotIdxT'(i);
		end
	end

endmodule

// ==== hw/DamageCalc.sv ====
`timescale 1ns/1ps
`include "battle_defines.svh"

module DamageCalc (
	input logic ClkPort,
	input logic Reset,
	input logic StrikeEn,
	LaneIf.view Lane,
	input BattlePkg::lanePosT FriendlyFront,
	input BattlePkg::lanePosT EnemyFront,
	input BattlePkg::slotIdxT UnitTarget,
	input BattlePkg::slotIdxT EnemyTarget,
	StrikeIf.source Strike
);

	logic [`BATTLE_SLOTS-1:0] unitMaskNext, enemyMaskNext;
	BattlePkg::damageT unitSum, enemySum;

	// range check and damage sum for both sides
	always_comb
	begin
		unitSum = '0;
		enemySum = '0;
		for (int i = 0; i < `BATTLE_SLOTS; i++)
		begin
			unitMaskNext[i] = Lane.unitAlive[i] &&
				(Lane.unitPos[i] + BattlePkg::lanePosT'(`BATTLE_RANGE) >= EnemyFront);
			enemyMaskNext[i] = Lane.enemyAlive[i] &&
				(Lane.enemyPos[i] <= FriendlyFront + BattlePkg::lanePosT'(`BATTLE_RANGE));
			if (unitMaskNext[i])
				unitSum = unitSum + BattlePkg::damageT'(BattlePkg::kindAttack[Lane.unitKind[i]]);
			if (enemyMaskNext[i])
				enemySum = enemySum + BattlePkg::damageT'(BattlePkg::kindAttack[Lane.enemyKind[i]]);
		end
	end

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
		begin
			Strike.unitMask <= '0;
			Strike.enemyMask <= '0;
			Strike.unitTowerHit <= 1'b0;
			Strike.enemyTowerHit <= 1'b0;
		end
		else if (StrikeEn)
		begin
			Strike.unitMask <= unitMaskNext;
			Strike.enemyMask <= enemyMaskNext;
			// nobody left to hit, so it lands on the tower
			Strike.unitTowerHit <= ~|Lane.enemyAlive;
			Strike.enemyTowerHit <= ~|Lane.unitAlive;
		end
	end

	// friendly damage lands on the enemy front slot and vice versa
	always_ff @(posedge ClkPort)
	begin
		if (StrikeEn)
		begin
			Strike.unitDamage <= unitSum;
			Strike.enemyDamage <= enemySum;
			Strike.unitTarget <= EnemyTarget;
			Strike.enemyTarget <= UnitTarget;
		end
	end

endmodule

// ==== hw/LaneState.sv ====
`timescale 1ns/1ps
`include "battle_defines.svh"

module LaneState (
	input logic ClkPort,
	input logic Reset,
	input logic ApplyEn,
	input logic SpawnUnit,
	input logic SpawnEnemy,
	input BattlePkg::unitKindT SpawnKind,
	input BattlePkg::unitKindT EnemyKind,
	StrikeIf.sink Strike,
	LaneIf.state Lane,
	output BattlePkg::healthT FriendlyTowerHealth,
	output BattlePkg::healthT EnemyTowerHealth
);

	logic [`BATTLE_SLOTS-1:0] unitAlive, unitAliveNext, enemyAlive, enemyAliveNext;
	BattlePkg::lanePosT unitPos [`BATTLE_SLOTS];
	BattlePkg::lanePosT unitPosNext [`BATTLE_SLOTS];
	BattlePkg::lanePosT enemyPos [`BATTLE_SLOTS];
	BattlePkg::lanePosT enemyPosNext [`BATTLE_SLOTS];
	BattlePkg::unitKindT unitKind [`BATTLE_SLOTS];
	BattlePkg::unitKindT unitKindNext [`BATTLE_SLOTS];
	BattlePkg::unitKindT enemyKind [`BATTLE_SLOTS];
	BattlePkg::unitKindT enemyKindNext [`BATTLE_SLOTS];
	BattlePkg::healthT unitHealth [`BATTLE_SLOTS];
	BattlePkg::healthT unitHealthNext [`BATTLE_SLOTS];
	BattlePkg::healthT enemyHealth [`BATTLE_SLOTS];
	BattlePkg::healthT enemyHealthNext [`BATTLE_SLOTS];
	logic unitPlaced, enemyPlaced;

	// spawn request delay line, stage 1 holds the value seen at Step
	logic [1:0] unitReq, enemyReq;
	BattlePkg::unitKindT unitReqKind [2];
	BattlePkg::unitKindT enemyReqKind [2];

	function automatic BattlePkg::healthT satSub(input BattlePkg::healthT h,
		input BattlePkg::damageT d);
		if (d >= BattlePkg::damageT'(h))
			return '0;
		return h - d[7:0];
	endfunction

	//////////////////////////////
	// next slot contents
	//////////////////////////////

	always_comb
	begin
		unitPlaced = 1'b0;
		enemyPlaced = 1'b0;
		for (int i = 0; i < `BATTLE_SLOTS; i++)
		begin
			unitHealthNext[i] = unitHealth[i];
			enemyHealthNext[i] = enemyHealth[i];
			if (!Strike.enemyTowerHit && Strike.enemyTarget == BattlePkg::slotIdxT'(i))
				unitHealthNext[i] = satSub(unitHealth[i], Strike.enemyDamage);
			if (!Strike.unitTowerHit && Strike.unitTarget == BattlePkg::slotIdxT'(i))
				enemyHealthNext[i] = satSub(enemyHealth[i], Strike.unitDamage);
			// zero health frees the slot
			unitAliveNext[i] = unitAlive[i] && (unitHealthNext[i] != '0);
			enemyAliveNext[i] = enemyAlive[i] && (enemyHealthNext[i] != '0);

			// non-attackers march toward the other side
			unitPosNext[i] = unitPos[i];
			if (!Strike.unitMask[i] && unitPos[i] < BattlePkg::lanePosT'(`BATTLE_FIELD_END))
				unitPosNext[i] = unitPos[i] + BattlePkg::lanePosT'(1);
			enemyPosNext[i] = enemyPos[i];
			if (!Strike.enemyMask[i] && enemyPos[i] != '0)
				enemyPosNext[i] = enemyPos[i] - BattlePkg::lanePosT'(1);

			unitKindNext[i] = unitKind[i];
			enemyKindNext[i] = enemyKind[i];
		end

		// spawns go to the lowest slot free after this tick's damage
		for (int i = 0; i < `BATTLE_SLOTS; i++)
		begin
			if (unitReq[1] && !unitPlaced && !unitAliveNext[i])
			begin
				unitPlaced = 1'b1;
				unitAliveNext[i] = 1'b1;
				unitPosNext[i] = '0;
				unitKindNext[i] = unitReqKind[1];
				unitHealthNext[i] = BattlePkg::kindHealth[unitReqKind[1]];
			end
			if (enemyReq[1] && !enemyPlaced && !enemyAliveNext[i])
			begin
				enemyPlaced = 1'b1;
				enemyAliveNext[i] = 1'b1;
				enemyPosNext[i] = BattlePkg::lanePosT'(`BATTLE_FIELD_END);
				enemyKindNext[i] = enemyReqKind[1];
				enemyHealthNext[i] = BattlePkg::kindHealth[enemyReqKind[1]];
			end
		end
	end

	//////////////////////////////
	// registers
	//////////////////////////////

	// apply comes two edges after the accepted Step, so the request
	// sampled at Step sits in stage 1 exactly then
	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
		begin
			unitReq <= '0;
			enemyReq <= '0;
			unitAlive <= '0;
			enemyAlive <= '0;
			FriendlyTowerHealth <= BattlePkg::healthT'(`BATTLE_TOWER_HEALTH);
			EnemyTowerHealth <= BattlePkg::healthT'(`BATTLE_TOWER_HEALTH);
		end
		else
		begin
			unitReq <= {unitReq[0], SpawnUnit};
			enemyReq <= {enemyReq[0], SpawnEnemy};
			if (ApplyEn)
			begin
				unitAlive <= unitAliveNext;
				enemyAlive <= enemyAliveNext;
				if (Strike.enemyTowerHit)
					FriendlyTowerHealth <= satSub(FriendlyTowerHealth, Strike.enemyDamage);
				if (Strike.unitTowerHit)
					EnemyTowerHealth <= satSub(EnemyTowerHealth, Strike.unitDamage);
			end
		end
	end

	always_ff @(posedge ClkPort)
	begin
		unitReqKind[0] <= SpawnKind;
		unitReqKind[1] <= unitReqKind[0];
		enemyReqKind[0] <= EnemyKind;
		enemyReqKind[1] <= enemyReqKind[0];
		if (ApplyEn)
		begin
			unitPos <= unitPosNext;
			enemyPos <= enemyPosNext;
			unitKind <= unitKindNext;
			enemyKind <= enemyKindNext;
			unitHealth <= unitHealthNext;
			enemyHealth <= enemyHealthNext;
		end
	end

	assign Lane.unitAlive = unitAlive;
	assign Lane.unitPos = unitPos;
	assign Lane.unitKind = unitKind;
	assign Lane.unitHealth = unitHealth;
	assign Lane.enemyAlive = enemyAlive;
	assign Lane.enemyPos = enemyPos;
	assign Lane.enemyKind = enemyKind;
	assign Lane.enemyHealth = enemyHealth;

endmodule

// ==== hw/GameEngine.sv ====
`timescale 1ns/1ps

module GameEngine (
	input logic ClkPort,
	input logic Reset,
	input logic Step,
	output logic Busy,
	output logic StrikeEn,
	output logic ApplyEn,
	output logic Done
);

	BattlePkg::engineStateT state, stateNext;

	//////////////////////////////
	// tick sequencer
	//////////////////////////////

	always_comb
	begin
		stateNext = state;
		case (state)
			BattlePkg::Idle:
			begin
				// Done cycle still counts as busy
				if (Step && !Done)
					stateNext = BattlePkg::Strike;
			end
			BattlePkg::Strike:
				stateNext = BattlePkg::Apply;
			BattlePkg::Apply:
				stateNext = BattlePkg::Idle;
			default:
				stateNext = BattlePkg::Idle;
		endcase
	end

	always_ff @(posedge ClkPort or posedge Reset)
	begin
		if (Reset)
		begin
			state <= BattlePkg::Idle;
			Done <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			// one cycle pulse right after the lane update
			Done <= (state == BattlePkg::Apply);
		end
	end

	assign StrikeEn = (state == BattlePkg::Strike);
	assign ApplyEn = (state == BattlePkg::Apply);
	assign Busy = (state != BattlePkg::Idle) || Done;

endmodule

// ==== hw/BattleTop.sv ====
`timescale 1ns/1ps

module BattleTop (
	input logic ClkPort,
	input logic Reset,
	input logic Step,
	input logic SpawnUnit,
	input BattlePkg::unitKindT SpawnKind,
	input logic SpawnEnemy,
	input BattlePkg::unitKindT EnemyKind,
	output logic Busy,
	output logic Done,
	output BattlePkg::lanePosT FriendlyFront,
	output BattlePkg::lanePosT EnemyFront,
	output BattlePkg::slotCountT UnitCount,
	output BattlePkg::slotCountT EnemyCount,
	output BattlePkg::healthT FriendlyTowerHealth,
	output BattlePkg::healthT EnemyTowerHealth
);

	logic strikeEn, applyEn;
	BattlePkg::slotIdxT unitTarget, enemyTarget;

	LaneIf laneBus ();
	StrikeIf strikeBus ();

	GameEngine engine (.ClkPort(ClkPort), .Reset(Reset), .Step(Step), .Busy(Busy),
		.StrikeEn(strikeEn), .ApplyEn(applyEn), .Done(Done));

	// decode
	BattleFront front (.Lane(laneBus.view), .FriendlyFront(FriendlyFront),
		.EnemyFront(EnemyFront), .UnitTarget(unitTarget), .EnemyTarget(enemyTarget),
		.UnitCount(UnitCount), .EnemyCount(EnemyCount));

	// execute
	DamageCalc damage (.ClkPort(ClkPort), .Reset(Reset), .StrikeEn(strikeEn),
		.Lane(laneBus.view), .FriendlyFront(FriendlyFront), .EnemyFront(EnemyFront),
		.UnitTarget(unitTarget), .EnemyTarget(enemyTarget), .Strike(strikeBus.source));

	// result
	LaneState lane (.ClkPort(ClkPort), .Reset(Reset), .ApplyEn(applyEn),
		.SpawnUnit(SpawnUnit), .SpawnEnemy(SpawnEnemy), .SpawnKind(SpawnKind),
		.EnemyKind(EnemyKind), .Strike(strikeBus.sink), .Lane(laneBus.state),
		.FriendlyTowerHealth(FriendlyTowerHealth), .EnemyTowerHealth(EnemyTowerHealth));

endmodule

// ==== verification/battle_tb_table.svh ====
`ifndef BATTLE_TB_TABLE_SVH
`define BATTLE_TB_TABLE_SVH

// columns: ticks, hold, spawn unit, unit kind, spawn enemy, enemy kind,
//   friendly front, enemy front, unit count, enemy count, own tower, enemy tower
// hold keeps Step high through the busy cycles

localparam int rowCount = 29;

function automatic rowT tableRow(input int idx);
	rowT r;
	case (idx)
		// basic against runner, both close in one step per tick
		0: r = makeRow(1, 0, 1, basic, 1, runner, 0, 40, 1, 1, 100, 100);
		1: r = makeRow(1, 0, 0, basic, 0, basic, 1, 39, 1, 1, 100, 100);
		2: r = makeRow(1, 1, 0, basic, 0, basic, 2, 38, 1, 1, 100, 100);
		3: r = makeRow(16, 0, 0, basic, 0, basic, 18, 22, 1, 1, 100, 100);
		// gap of 4, both stop and trade hits
		4: r = makeRow(1, 0, 0, basic, 0, basic, 18, 22, 1, 1, 100, 100);
		5: r = makeRow(2, 0, 0, basic, 0, basic, 18, 40, 1, 0, 100, 100);
		// fill the friendly slots, fifth spawn is dropped
		6: r = makeRow(1, 0, 1, tank, 0, basic, 19, 40, 2, 0, 100, 100);
		7: r = makeRow(1, 0, 1, brute, 0, basic, 20, 40, 3, 0, 100, 100);
		8: r = makeRow(1, 0, 1, runner, 0, basic, 21, 40, 4, 0, 100, 100);
		9: r = makeRow(1, 0, 1, basic, 0, basic, 22, 40, 4, 0, 100, 100);
		// lead basic parks at 36 and hits the tower
		10: r = makeRow(14, 0, 0, basic, 0, basic, 36, 40, 4, 0, 100, 100);
		11: r = makeRow(1, 0, 0, basic, 0, basic, 36, 40, 4, 0, 100, 96);
		12: r = makeRow(18, 0, 0, basic, 0, basic, 36, 40, 4, 0, 100, 24);
		// tank, brute and runner join in turn, tower saturates at 0
		13: r = makeRow(1, 0, 0, basic, 0, basic, 36, 40, 4, 0, 100, 18);
		14: r = makeRow(1, 0, 0, basic, 0, basic, 36, 40, 4, 0, 100, 2);
		15: r = makeRow(1, 0, 0, basic, 0, basic, 36, 40, 4, 0, 100, 0);
		16: r = makeRow(1, 1, 0, basic, 0, basic, 36, 40, 4, 0, 100, 0);
		// enemy brutes wear the friendly line down one slot at a time
		17: r = makeRow(1, 0, 0, basic, 1, brute, 36, 40, 4, 1, 100, 0);
		18: r = makeRow(1, 0, 0, basic, 1, brute, 36, 40, 4, 1, 100, 0);
		19: r = makeRow(1, 0, 0, basic, 1, brute, 36, 40, 3, 1, 100, 0);
		20: r = makeRow(1, 0, 0, basic, 1, brute, 36, 40, 3, 2, 100, 0);
		21: r = makeRow(1, 0, 0, basic, 1, brute, 36, 40, 3, 2, 100, 0);
		22: r = makeRow(1, 0, 0, basic, 1, brute, 36, 40, 3, 3, 100, 0);
		23: r = makeRow(1, 0, 0, basic, 1, brute, 36, 40, 2, 3, 100, 0);
		24: r = makeRow(1, 0, 0, basic, 1, brute, 36, 40, 1, 4, 100, 0);
		25: r = makeRow(1, 0, 0, basic, 0, basic, 0, 40, 0, 3, 100, 0);
		// lane lost, three brutes march down and hit our tower
		26: r = makeRow(36, 0, 0, basic, 0, basic, 0, 4, 0, 3, 100, 0);
		27: r = makeRow(1, 0, 0, basic, 0, basic, 0, 4, 0, 3, 70, 0);
		28: r = makeRow(3, 0, 0, basic, 0, basic, 0, 4, 0, 3, 0, 0);
		default: r = '0;
	endcase
	return r;
endfunction

`endif

// ==== verification/BattleTb.sv ====
`timescale 1ns/1ps
`include "battle_defines.svh"

module BattleTb;

	// one table row, run for a number of ticks and checked after the last one
	typedef struct packed {
		logic [7:0] ticks;
		logic hold;
		logic spawnUnit;
		BattlePkg::unitKindT spawnKind;
		logic spawnEnemy;
		BattlePkg::unitKindT enemyKind;
		BattlePkg::lanePosT friendlyFront;
		BattlePkg::lanePosT enemyFront;
		BattlePkg::slotCountT unitCount;
		BattlePkg::slotCountT enemyCount;
		BattlePkg::healthT friendlyTower;
		BattlePkg::healthT enemyTower;
	} rowT;

	localparam BattlePkg::unitKindT basic = BattlePkg::Basic;
	localparam BattlePkg::unitKindT tank = BattlePkg::Tank;
	localparam BattlePkg::unitKindT brute = BattlePkg::Brute;
	localparam BattlePkg::unitKindT runner = BattlePkg::Runner;

	logic ClkPort;
	logic Reset;
	logic Step;
	logic SpawnUnit;
	BattlePkg::unitKindT SpawnKind;
	logic SpawnEnemy;
	BattlePkg::unitKindT EnemyKind;
	logic Busy;
	logic Done;
	BattlePkg::lanePosT FriendlyFront;
	BattlePkg::lanePosT EnemyFront;
	BattlePkg::slotCountT UnitCount;
	BattlePkg::slotCountT EnemyCount;
	BattlePkg::healthT FriendlyTowerHealth;
	BattlePkg::healthT EnemyTowerHealth;

	int cycleCount = 0;
	int cycleLimit;

	function automatic rowT makeRow(input int ticks, input bit hold, input bit su,
		input BattlePkg::unitKindT sk, input bit se, input BattlePkg::unitKindT ek,
		input int ff, input int ef, input int uc, input int ec, input int ft, input int et);
		rowT r;
		r.ticks = 8'(ticks);
		r.hold = hold;
		r.spawnUnit = su;
		r.spawnKind = sk;
		r.spawnEnemy = se;
		r.enemyKind = ek;
		r.friendlyFront = BattlePkg::lanePosT'(ff);
		r.enemyFront = BattlePkg::lanePosT'(ef);
		r.unitCount = BattlePkg::slotCountT'(uc);
		r.enemyCount = BattlePkg::slotCountT'(ec);
		r.friendlyTower = BattlePkg::healthT'(ft);
		r.enemyTower = BattlePkg::healthT'(et);
		return r;
	endfunction

	`include "battle_tb_table.svh"

	BattleTop uut (.ClkPort(ClkPort), .Reset(Reset), .Step(Step), .SpawnUnit(SpawnUnit),
		.SpawnKind(SpawnKind), .SpawnEnemy(SpawnEnemy), .EnemyKind(EnemyKind),
		.Busy(Busy), .Done(Done), .FriendlyFront(FriendlyFront), .EnemyFront(EnemyFront),
		.UnitCount(UnitCount), .EnemyCount(EnemyCount),
		.FriendlyTowerHealth(FriendlyTowerHealth), .EnemyTowerHealth(EnemyTowerHealth));

	//////////////////////////////
	// reporting and compares
	//////////////////////////////

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic checkBit(input logic got, input logic want, input string what);
		if (got !== want)
			abortRun($sformatf("mismatch at %0t: %s is %b, expected %b", $time, what, got, want));
	endtask

	task automatic checkPos(input BattlePkg::lanePosT got, input BattlePkg::lanePosT want,
		input string what);
		if (got !== want)
			abortRun($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want));
	endtask

	task automatic checkCount(input BattlePkg::slotCountT got, input BattlePkg::slotCountT want,
		input string what);
		if (got !== want)
			abortRun($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want));
	endtask

	task automatic checkHealth(input BattlePkg::healthT got, input BattlePkg::healthT want,
		input string what);
		if (got !== want)
			abortRun($sformatf("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want));
	endtask

	task automatic compareRow(input int idx, input rowT row);
		checkPos(FriendlyFront, row.friendlyFront, $sformatf("row %0d friendly front", idx));
		checkPos(EnemyFront, row.enemyFront, $sformatf("row %0d enemy front", idx));
		checkCount(UnitCount, row.unitCount, $sformatf("row %0d unit count", idx));
		checkCount(EnemyCount, row.enemyCount, $sformatf("row %0d enemy count", idx));
		checkHealth(FriendlyTowerHealth, row.friendlyTower, $sformatf("row %0d own tower", idx));
		checkHealth(EnemyTowerHealth, row.enemyTower, $sformatf("row %0d enemy tower", idx));
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	// one accepted Step, returns at the negedge where Done is high
	task automatic runTick(input logic hold, input logic su, input BattlePkg::unitKindT sk,
		input logic se, input BattlePkg::unitKindT ek);
		@(posedge ClkPort);
		Step <= 1'b1;
		SpawnUnit <= su;
		SpawnKind <= sk;
		SpawnEnemy <= se;
		EnemyKind <= ek;
		@(negedge ClkPort);
		checkBit(Busy, 1'b0, "Busy before Step");
		checkBit(Done, 1'b0, "Done before Step");
		// Step is accepted at this edge
		@(posedge ClkPort);
		if (!hold)
			Step <= 1'b0;
		SpawnUnit <= 1'b0;
		SpawnEnemy <= 1'b0;
		for (int k = 1; k <= 3; k++)
		begin
			@(negedge ClkPort);
			checkBit(Busy, 1'b1, "Busy during tick");
			if (Done && k < 3)
				abortRun($sformatf("Done came %0d cycles after the accepted Step, too early", k));
		end
		if (!Done)
			abortRun("Done did not arrive three cycles after the accepted Step");
	endtask

	function automatic int totalTicks();
		int sum;
		sum = 0;
		for (int i = 0; i < rowCount; i++)
			sum += int'(tableRow(i).ticks);
		return sum;
	endfunction

	initial
	begin
		ClkPort = 1'b0;
		forever
			#20 ClkPort = ~ClkPort;
	end

	always @(posedge ClkPort)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			abortRun($sformatf("timeout, the run did not finish within %0d cycles", cycleLimit));
	end

	initial
	begin
		rowT row;
		cycleLimit = 4 * totalTicks() + 20;
		Reset = 1'b1;
		Step = 1'b0;
		SpawnUnit = 1'b0;
		SpawnKind = basic;
		SpawnEnemy = 1'b0;
		EnemyKind = basic;
		repeat (2)
			@(posedge ClkPort);
		Reset <= 1'b0;

		// empty lane, full towers
		@(negedge ClkPort);
		checkBit(Busy, 1'b0, "Busy after reset");
		checkBit(Done, 1'b0, "Done after reset");
		checkPos(FriendlyFront, '0, "friendly front after reset");
		checkPos(EnemyFront, `BATTLE_FIELD_END, "enemy front after reset");
		checkCount(UnitCount, '0, "unit count after reset");
		checkCount(EnemyCount, '0, "enemy count after reset");
		checkHealth(FriendlyTowerHealth, `BATTLE_TOWER_HEALTH, "own tower after reset");
		checkHealth(EnemyTowerHealth, `BATTLE_TOWER_HEALTH, "enemy tower after reset");

		for (int i = 0; i < rowCount; i++)
		begin
			row = tableRow(i);
			// spawns only go with the first tick of a row
			for (int t = 0; t < int'(row.ticks); t++)
				runTick(row.hold, row.spawnUnit && t == 0, row.spawnKind,
					row.spawnEnemy && t == 0, row.enemyKind);
			compareRow(i, row);
		end

		@(posedge ClkPort);
		Step <= 1'b0;
		@(negedge ClkPort);
		checkBit(Busy, 1'b0, "Busy after the last tick");
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+hw
+incdir+verification
hw/BattlePkg.sv
hw/LaneIf.sv
hw/BattleFront.sv
hw/DamageCalc.sv
hw/LaneState.sv
hw/GameEngine.sv
hw/BattleTop.sv
verification/BattleTb.sv

// ==== Bender.yml ====
package:
  name: battle_core

export_include_dirs:
  - hw

sources:
  - files:
      - hw/BattlePkg.sv
      - hw/LaneIf.sv
      - hw/BattleFront.sv
      - hw/DamageCalc.sv
      - hw/LaneState.sv
      - hw/GameEngine.sv
      - hw/BattleTop.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/BattleTb.sv
